/* src/tanimoto_config.svh */
`ifndef TANIMOTO_CONFIG_SVH
`define TANIMOTO_CONFIG_SVH

// One vector is a single bus word
`define VEC_WIDTH 32

// Popcount of a full vector, 0 to 32
`define CNT_WIDTH 6

// Sum of two popcounts, also the width of a threshold entry
`define SUM_WIDTH 7

`define ID_WIDTH 8

// Reference vectors and compare lanes, kept a power of two for the merge tree
`define REF_DEPTH 4

`define FIFO_DEPTH 8
`define FIFO_CNT_WIDTH 4

`endif

/* src/tanimoto_pkg.sv */
`include "tanimoto_config.svh"

package tanimoto_pkg;

    typedef logic [`VEC_WIDTH-1:0] vec_t;

    typedef logic [`CNT_WIDTH-1:0] cnt_t;

    // a + b, or one threshold table entry
    typedef logic [`SUM_WIDTH-1:0] sum_t;

    typedef logic [`ID_WIDTH-1:0] id_t;

    // Ref ID in the upper byte, candidate ID in the lower byte
    typedef logic [2*`ID_WIDTH-1:0] id_pair_t;

    typedef enum logic {
        LOAD_REF = 1'b0,
        COMPARE  = 1'b1
    } phase_e;

endpackage

/* src/popcount_pipe.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module popcount_pipe (
    input  logic               clk,
    input  logic               rst,
    input  tanimoto_pkg::vec_t i_vec,
    input  logic               i_valid,
    output tanimoto_pkg::vec_t o_vec,
    output tanimoto_pkg::cnt_t o_cnt,
    output logic               o_valid
);

    localparam int NUM_BYTES = `VEC_WIDTH / 8;

    // A byte holds at most 8 ones, so four bits per partial count
    logic [3:0]         byte_cnt   [NUM_BYTES];
    logic [3:0]         byte_cnt_q [NUM_BYTES];
    tanimoto_pkg::vec_t vec_q;
    logic               valid_q;
    tanimoto_pkg::cnt_t cnt_sum;

    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            byte_cnt[b] = '0;
            for (int k = 0; k < 8; k++) begin
                byte_cnt[b] = byte_cnt[b] + 4'(i_vec[8*b+k]);
            end
        end
    end

    // Second stage adds the registered byte counts
    always_comb begin
        cnt_sum = '0;
        for (int b = 0; b < NUM_BYTES; b++) begin
            cnt_sum = cnt_sum + tanimoto_pkg::cnt_t'(byte_cnt_q[b]);
        end
    end

    always_ff @(posedge clk) begin
        byte_cnt_q <= byte_cnt;
        vec_q      <= i_vec;
        o_vec      <= vec_q;
        o_cnt      <= cnt_sum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= i_valid;
            o_valid <= valid_q;
        end
    end

endmodule

/* src/ref_store.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module ref_store (
    input  logic               clk,
    input  logic               rst,
    input  tanimoto_pkg::vec_t i_vec,
    input  tanimoto_pkg::cnt_t i_cnt,
    input  logic               i_valid,
    output logic               o_cand_valid,
    output tanimoto_pkg::vec_t o_cand_vec,
    output tanimoto_pkg::cnt_t o_cand_cnt,
    output tanimoto_pkg::id_t  o_cand_id,
    output tanimoto_pkg::vec_t o_ref_vec [`REF_DEPTH],
    output tanimoto_pkg::cnt_t o_ref_cnt [`REF_DEPTH],
    output tanimoto_pkg::id_t  o_ref_id  [`REF_DEPTH]
);

    tanimoto_pkg::phase_e phase;
    tanimoto_pkg::id_t    id_cnt;
    logic                 shift_ref;
    logic                 take_cand;

    assign shift_ref = i_valid && (phase == tanimoto_pkg::LOAD_REF);
    assign take_cand = i_valid && (phase == tanimoto_pkg::COMPARE);

    // ID is the arrival number of the vector since reset
    always_ff @(posedge clk) begin
        if (rst) begin
            phase        <= tanimoto_pkg::LOAD_REF;
            id_cnt       <= '0;
            o_cand_valid <= 1'b0;
        end else begin
            o_cand_valid <= take_cand;
            if (i_valid) begin
                id_cnt <= id_cnt + 1'b1;
            end
            // Last reference slot filled this cycle
            if (shift_ref && (id_cnt == tanimoto_pkg::id_t'(`REF_DEPTH - 1))) begin
                phase <= tanimoto_pkg::COMPARE;
            end
        end
    end

    // Newest reference enters at lane 0
    always_ff @(posedge clk) begin
        if (shift_ref) begin
            o_ref_vec[0] <= i_vec;
            o_ref_cnt[0] <= i_cnt;
            o_ref_id[0]  <= id_cnt;
            for (int i = 1; i < `REF_DEPTH; i++) begin
                o_ref_vec[i] <= o_ref_vec[i-1];
                o_ref_cnt[i] <= o_ref_cnt[i-1];
                o_ref_id[i]  <= o_ref_id[i-1];
            end
        end
    end

    // Candidate is broadcast to every lane at once
    always_ff @(posedge clk) begin
        if (take_cand) begin
            o_cand_vec <= i_vec;
            o_cand_cnt <= i_cnt;
            o_cand_id  <= id_cnt;
        end
    end

endmodule

/* src/threshold_table.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module threshold_table (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_we,
    input  tanimoto_pkg::cnt_t i_waddr,
    input  tanimoto_pkg::sum_t i_wdata,
    input  tanimoto_pkg::cnt_t i_raddr [`REF_DEPTH],
    output tanimoto_pkg::sum_t o_rdata [`REF_DEPTH]
);

    // One entry per possible value of CNT(ref AND cand)
    tanimoto_pkg::sum_t thr [`VEC_WIDTH+1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e <= `VEC_WIDTH; e++) begin
                thr[e] <= '0;
            end
        end else if (i_we && (i_waddr <= `VEC_WIDTH)) begin
            thr[i_waddr] <= i_wdata;
        end
    end

    // Separate registered read port per lane
    always_ff @(posedge clk) begin
        for (int l = 0; l < `REF_DEPTH; l++) begin
            if (i_raddr[l] <= `VEC_WIDTH) begin
                o_rdata[l] <= thr[i_raddr[l]];
            end else begin
                o_rdata[l] <= '0;
            end
        end
    end

endmodule

/* src/match_lane.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module match_lane (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_cand_valid,
    input  tanimoto_pkg::vec_t     i_cand_vec,
    input  tanimoto_pkg::cnt_t     i_cand_cnt,
    input  tanimoto_pkg::id_t      i_cand_id,
    input  tanimoto_pkg::vec_t     i_ref_vec,
    input  tanimoto_pkg::cnt_t     i_ref_cnt,
    input  tanimoto_pkg::id_t      i_ref_id,
    output tanimoto_pkg::cnt_t     o_thr_addr,
    input  tanimoto_pkg::sum_t     i_thr_data,
    output logic                   o_hit,
    output tanimoto_pkg::id_pair_t o_pair
);

    tanimoto_pkg::vec_t     and_vec;
    logic                   and_valid;
    tanimoto_pkg::cnt_t     and_cnt;
    logic                   and_cnt_valid;
    logic                   cmp_valid;
    // Index 0 is cycle +1, index 3 lines up with the table data
    tanimoto_pkg::sum_t     sum_dly  [4];
    tanimoto_pkg::id_pair_t pair_dly [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            and_valid <= 1'b0;
            cmp_valid <= 1'b0;
        end else begin
            and_valid <= i_cand_valid;
            cmp_valid <= and_cnt_valid;
        end
    end

    always_ff @(posedge clk) begin
        and_vec     <= i_ref_vec & i_cand_vec;
        sum_dly[0]  <= tanimoto_pkg::sum_t'(i_ref_cnt) + tanimoto_pkg::sum_t'(i_cand_cnt);
        pair_dly[0] <= {i_ref_id, i_cand_id};
        for (int i = 1; i < 4; i++) begin
            sum_dly[i]  <= sum_dly[i-1];
            pair_dly[i] <= pair_dly[i-1];
        end
    end

    // c = CNT(ref AND cand), ready at cycle +3
    popcount_pipe u_and_cnt (
        .clk     (clk),
        .rst     (rst),
        .i_vec   (and_vec),
        .i_valid (and_valid),
        .o_vec   (),
        .o_cnt   (and_cnt),
        .o_valid (and_cnt_valid)
    );

    assign o_thr_addr = and_cnt;

    // Hit when a + b does not exceed the entry for c
    assign o_hit  = cmp_valid && (sum_dly[3] <= i_thr_data);
    assign o_pair = pair_dly[3];

endmodule

/* src/id_fifo.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module id_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_wr,
    input  tanimoto_pkg::id_pair_t       i_din,
    input  logic                         i_rd,
    output tanimoto_pkg::id_pair_t       o_dout,
    output logic                         o_empty,
    output logic                         o_full,
    output logic [`FIFO_CNT_WIDTH-1:0]   o_count
);

    localparam int PTR_WIDTH = $clog2(`FIFO_DEPTH);
    localparam logic [`FIFO_CNT_WIDTH-1:0] FULL_COUNT = `FIFO_DEPTH;

    tanimoto_pkg::id_pair_t mem [`FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic                   do_wr;
    logic                   do_rd;

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == FULL_COUNT);

    // Writes to a full FIFO and reads from an empty one are ignored
    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    // Head entry is visible without a read strobe
    assign o_dout = mem[rd_ptr];

endmodule

/* src/id_merge_tree.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module id_merge_tree (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REF_DEPTH-1:0]  i_hit,
    input  tanimoto_pkg::id_pair_t i_pair [`REF_DEPTH],
    input  logic                   i_read,
    output tanimoto_pkg::id_pair_t o_pair,
    output logic                   o_valid
);

    // Heap numbering, node 1 is the root, children of n are 2n and 2n+1
    localparam int NODES = 2 * `REF_DEPTH;

    logic                        fifo_wr    [1:NODES-1];
    tanimoto_pkg::id_pair_t      fifo_din   [1:NODES-1];
    logic                        fifo_rd    [1:NODES-1];
    tanimoto_pkg::id_pair_t      fifo_dout  [1:NODES-1];
    logic                        fifo_empty [1:NODES-1];
    logic                        fifo_full  [1:NODES-1];
    logic [`FIFO_CNT_WIDTH-1:0]  fifo_count [1:NODES-1];

    for (genvar n = 1; n < NODES; n++) begin : g_node
        id_fifo u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_wr    (fifo_wr[n]),
            .i_din   (fifo_din[n]),
            .i_rd    (fifo_rd[n]),
            .o_dout  (fifo_dout[n]),
            .o_empty (fifo_empty[n]),
            .o_full  (fifo_full[n]),
            .o_count (fifo_count[n])
        );

        if (n >= `REF_DEPTH) begin : g_leaf
            // Leaf per lane, hits at a full leaf are lost
            assign fifo_wr[n]  = i_hit[n-`REF_DEPTH];
            assign fifo_din[n] = i_pair[n-`REF_DEPTH];
        end else begin : g_merge
            logic take_left;
            logic move;

            // Fuller child goes first, left wins a tie
            assign take_left = (fifo_count[2*n] >= fifo_count[2*n+1]);
            assign move = (take_left ? !fifo_empty[2*n] : !fifo_empty[2*n+1]) && !fifo_full[n];

            assign fifo_wr[n]     = move;
            assign fifo_din[n]    = take_left ? fifo_dout[2*n] : fifo_dout[2*n+1];
            assign fifo_rd[2*n]   = move && take_left;
            assign fifo_rd[2*n+1] = move && !take_left;
        end
    end

    assign fifo_rd[1] = i_read;
    assign o_pair     = fifo_dout[1];
    assign o_valid    = !fifo_empty[1];

endmodule

/* src/tanimoto_top.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module tanimoto_top (
    input  logic                   clk,
    input  logic                   rst,
    input  tanimoto_pkg::vec_t     i_vec,
    input  logic                   i_valid,
    input  logic                   i_thr_we,
    input  tanimoto_pkg::cnt_t     i_thr_addr,
    input  tanimoto_pkg::sum_t     i_thr_data,
    input  logic                   i_pair_read,
    output tanimoto_pkg::id_pair_t o_pair,
    output logic                   o_pair_valid
);

    tanimoto_pkg::vec_t     in_vec;
    tanimoto_pkg::cnt_t     in_cnt;
    logic                   in_valid;

    logic                   cand_valid;
    tanimoto_pkg::vec_t     cand_vec;
    tanimoto_pkg::cnt_t     cand_cnt;
    tanimoto_pkg::id_t      cand_id;
    tanimoto_pkg::vec_t     ref_vec [`REF_DEPTH];
    tanimoto_pkg::cnt_t     ref_cnt [`REF_DEPTH];
    tanimoto_pkg::id_t      ref_id  [`REF_DEPTH];

    tanimoto_pkg::cnt_t     thr_addr [`REF_DEPTH];
    tanimoto_pkg::sum_t     thr_data [`REF_DEPTH];
    logic [`REF_DEPTH-1:0]  lane_hit;
    tanimoto_pkg::id_pair_t lane_pair [`REF_DEPTH];

    // b = CNT(vector), also a for the vectors kept as references
    popcount_pipe u_in_cnt (
        .clk     (clk),
        .rst     (rst),
        .i_vec   (i_vec),
        .i_valid (i_valid),
        .o_vec   (in_vec),
        .o_cnt   (in_cnt),
        .o_valid (in_valid)
    );

    ref_store u_ref_store (
        .clk          (clk),
        .rst          (rst),
        .i_vec        (in_vec),
        .i_cnt        (in_cnt),
        .i_valid      (in_valid),
        .o_cand_valid (cand_valid),
        .o_cand_vec   (cand_vec),
        .o_cand_cnt   (cand_cnt),
        .o_cand_id    (cand_id),
        .o_ref_vec    (ref_vec),
        .o_ref_cnt    (ref_cnt),
        .o_ref_id     (ref_id)
    );

    threshold_table u_thr_table (
        .clk     (clk),
        .rst     (rst),
        .i_we    (i_thr_we),
        .i_waddr (i_thr_addr),
        .i_wdata (i_thr_data),
        .i_raddr (thr_addr),
        .o_rdata (thr_data)
    );

    for (genvar l = 0; l < `REF_DEPTH; l++) begin : g_lane
        match_lane u_lane (
            .clk          (clk),
            .rst          (rst),
            .i_cand_valid (cand_valid),
            .i_cand_vec   (cand_vec),
            .i_cand_cnt   (cand_cnt),
            .i_cand_id    (cand_id),
            .i_ref_vec    (ref_vec[l]),
            .i_ref_cnt    (ref_cnt[l]),
            .i_ref_id     (ref_id[l]),
            .o_thr_addr   (thr_addr[l]),
            .i_thr_data   (thr_data[l]),
            .o_hit        (lane_hit[l]),
            .o_pair       (lane_pair[l])
        );
    end

    id_merge_tree u_merge_tree (
        .clk     (clk),
        .rst     (rst),
        .i_hit   (lane_hit),
        .i_pair  (lane_pair),
        .i_read  (i_pair_read),
        .o_pair  (o_pair),
        .o_valid (o_pair_valid)
    );

endmodule

/* verif/tb_tanimoto.sv */
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module tb_tanimoto;

    localparam int CLK_PERIOD  = 8;
    // Total of 40 + 8 + 8 + 6 + 24 candidates over all tests
    localparam int NUM_CAND    = 86;
    localparam int WATCHDOG_NS = (NUM_CAND + 200) * 8 * CLK_PERIOD;
    localparam int DRAIN_LIMIT = 400;
    localparam int SETTLE      = 24;

    logic                   clk;
    logic                   rst;
    logic [`VEC_WIDTH-1:0]  i_vec;
    logic                   i_valid;
    logic                   i_thr_we;
    logic [`CNT_WIDTH-1:0]  i_thr_addr;
    logic [`SUM_WIDTH-1:0]  i_thr_data;
    logic                   i_pair_read;
    logic [2*`ID_WIDTH-1:0] o_pair;
    logic                   o_pair_valid;

    // Reference model state
    logic [31:0] rng_state;
    logic [31:0] refs [0:`REF_DEPTH-1];
    int          thr_model [0:`VEC_WIDTH];
    logic [15:0] exp_mem [0:`REF_DEPTH-1][0:255];
    int          head [0:`REF_DEPTH-1];
    int          tail [0:`REF_DEPTH-1];
    int          next_id;
    bit          rand_reads;
    string       test_name;

    tanimoto_top tanimoto_top_i (
        .clk          (clk),
        .rst          (rst),
        .i_vec        (i_vec),
        .i_valid      (i_valid),
        .i_thr_we     (i_thr_we),
        .i_thr_addr   (i_thr_addr),
        .i_thr_data   (i_thr_data),
        .i_pair_read  (i_pair_read),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int ones(input logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n = n + v[i];
        end
        return n;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int r = 0; r < `REF_DEPTH; r++) begin
            n = n + (tail[r] - head[r]);
        end
        return n;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("** Error: %s expected %0h actual %0h",
                                    name, expected, actual));
        end
    endtask

    // First REF_DEPTH vectors become references, later ones are scored per lane
    task automatic record_vector(input logic [31:0] v);
        int a;
        int b;
        int c;
        if (next_id < `REF_DEPTH) begin
            refs[next_id] = v;
        end else begin
            for (int r = 0; r < `REF_DEPTH; r++) begin
                a = ones(refs[r]);
                b = ones(v);
                c = ones(refs[r] & v);
                if (a + b <= thr_model[c]) begin
                    exp_mem[r][tail[r]] = {8'(r), 8'(next_id)};
                    tail[r]++;
                end
            end
        end
        next_id++;
    endtask

    // One negedge step of stimulus
    task automatic tick(input logic valid, input logic [31:0] vec);
        logic [31:0] rnd;
        @(negedge clk);
        i_valid  = valid;
        i_vec    = vec;
        i_thr_we = 1'b0;
        if (rand_reads) begin
            rnd         = next_rand();
            i_pair_read = rnd[7];
        end
        if (valid) begin
            record_vector(vec);
        end
    endtask

    task automatic write_entry(input int addr, input int data);
        @(negedge clk);
        i_valid         = 1'b0;
        i_thr_we        = 1'b1;
        i_thr_addr      = addr[`CNT_WIDTH-1:0];
        i_thr_data      = data[`SUM_WIDTH-1:0];
        thr_model[addr] = data & 127;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending_count() != 0) begin
            tick(1'b0, '0);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                stop_on_error($sformatf("Expected pairs never reached the output in %s",
                                        test_name));
            end
        end
        // Late extra pairs show up as unexpected in the collector
        repeat (SETTLE) tick(1'b0, '0);
    endtask

    // Pairs pop on the edge where read and valid are both high
    initial begin
        logic [15:0] pair;
        int          rid;
        forever begin
            @(posedge clk);
            if (!rst && o_pair_valid && i_pair_read) begin
                pair = o_pair;
                rid  = pair[15:8];
                if (rid >= `REF_DEPTH || head[rid] == tail[rid]) begin
                    stop_on_error($sformatf("Unexpected pair %04h seen in %s", pair, test_name));
                end else begin
                    check_value(test_name, exp_mem[rid][head[rid]], pair);
                    head[rid]++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("Timeout, the output never drained");
    end

    initial begin
        int cnt;
        rng_state   = 32'd87424;
        rst         = 1'b1;
        i_vec       = '0;
        i_valid     = 1'b0;
        i_thr_we    = 1'b0;
        i_thr_addr  = '0;
        i_thr_data  = '0;
        i_pair_read = 1'b0;
        next_id     = 0;
        rand_reads  = 1'b0;
        test_name   = "reset";
        for (int r = 0; r < `REF_DEPTH; r++) begin
            head[r] = 0;
            tail[r] = 0;
        end
        for (int e = 0; e <= `VEC_WIDTH; e++) begin
            thr_model[e] = 0;
        end
        repeat (5) @(negedge clk);
        rst         = 1'b0;
        i_pair_read = 1'b1;

        // No pair may exist before the compare phase
        check_value(test_name, 0, o_pair_valid);
        for (int i = 0; i < `REF_DEPTH + 12; i++) begin
            tick(i < `REF_DEPTH, next_rand());
            check_value(test_name, 0, o_pair_valid);
        end

        test_name = "programmable_threshold";
        for (int e = 0; e <= `VEC_WIDTH; e++) begin
            write_entry(e, next_rand() % 65);
        end
        repeat (40) begin
            tick(1'b1, next_rand());
            repeat (2) tick(1'b0, '0);
        end
        drain();

        test_name = "exact_boundary";
        for (int e = 0; e <= `VEC_WIDTH; e++) begin
            write_entry(e, 0);
        end
        for (int r = 0; r < `REF_DEPTH; r++) begin
            cnt = ones(refs[r]);
            write_entry(cnt, 2 * cnt);
            tick(1'b1, refs[r]);
            drain();
            write_entry(cnt, 2 * cnt - 1);
            tick(1'b1, refs[r]);
            drain();
            write_entry(cnt, 0);
        end

        // All-ones entries make every lane hit on every candidate
        test_name = "back_to_back";
        for (int e = 0; e <= `VEC_WIDTH; e++) begin
            write_entry(e, 127);
        end
        repeat (8) tick(1'b1, next_rand());
        drain();

        test_name = "back_pressure";
        i_pair_read = 1'b0;
        repeat (6) tick(1'b1, next_rand());
        repeat (SETTLE) tick(1'b0, '0);
        check_value(test_name, 1, o_pair_valid);
        i_pair_read = 1'b1;
        drain();

        test_name = "random_reads";
        for (int e = 0; e <= `VEC_WIDTH; e++) begin
            write_entry(e, next_rand() % 65);
        end
        rand_reads = 1'b1;
        repeat (24) begin
            tick(1'b1, next_rand());
            repeat (3) tick(1'b0, '0);
        end
        rand_reads  = 1'b0;
        i_pair_read = 1'b1;
        drain();

        $display("Regression passed");
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/tanimoto_pkg.sv
src/popcount_pipe.sv
src/ref_store.sv
src/threshold_table.sv
src/match_lane.sv
src/id_fifo.sv
src/id_merge_tree.sv
src/tanimoto_top.sv
verif/tb_tanimoto.sv
